/* design/trigger_pattern_pkg.sv */
`default_nettype none

package trigger_pattern_pkg;

	// bits per frame, sent MSB first
	localparam int WORD_WIDTH = 8;

	// width of the serializer bit counter
	localparam int BIT_COUNT_WIDTH = $clog2(WORD_WIDTH);

	// self-trigger period is 2**SELF_TRIGGER_LOG2 cycles
	localparam int SELF_TRIGGER_LOG2 = 6;

	typedef logic [WORD_WIDTH-1:0] pattern_word_t;

	typedef logic [1:0] pattern_index_t;

	// rotation order, index 0 first
	localparam pattern_word_t PATTERN_TABLE [0:3] = '{
		8'b11110000,
		8'b10000001,
		8'b10001000,
		8'b10101010
	};

	// from the input side to the sequencer
	typedef struct packed {
		logic ext_pulse;
		logic self_mode;
	} trigger_event_t;

	// from the sequencer to the serializer
	typedef struct packed {
		logic load;
		pattern_index_t index;
		pattern_word_t word;
	} frame_t;

endpackage

`default_nettype wire

/* design/trigger_input.sv */
`timescale 1ns/1ps
`default_nettype none

module trigger_input (
	input logic clock,
	input logic reset1,
	input logic trigger_level,
	input logic self_mode_switch,
	output trigger_pattern_pkg::trigger_event_t trigger_event
);

	// synchronizer stages for the trigger
	logic trigger_meta;
	logic trigger_sync;
	// delayed copy for the rise detector
	logic trigger_last;
	logic ext_pulse_q;

	// synchronizer stages for the mode switch
	logic mode_meta;
	logic mode_sync;

	always_ff @(posedge clock) begin
		if (reset1) begin
			trigger_meta <= 1'b0;
			trigger_sync <= 1'b0;
			trigger_last <= 1'b0;
			ext_pulse_q <= 1'b0;
			mode_meta <= 1'b0;
			mode_sync <= 1'b0;
		end else begin
			trigger_meta <= trigger_level;
			trigger_sync <= trigger_meta;
			trigger_last <= trigger_sync;
			// one pulse per rise, a held level gives nothing more
			ext_pulse_q <= trigger_sync & ~trigger_last;
			mode_meta <= self_mode_switch;
			mode_sync <= mode_meta;
		end
	end

	assign trigger_event = '{
		ext_pulse: ext_pulse_q,
		self_mode: mode_sync
	};

	// edge detector output is a single-cycle strobe
	assert property (@(posedge clock) disable iff (reset1)
		ext_pulse_q |=> !ext_pulse_q)
	else $error("ext_pulse high in two consecutive cycles");

endmodule

`default_nettype wire

/* design/self_trigger_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module self_trigger_timer (
	input logic clock,
	input logic reset1,
	output logic self_pulse
);

	import trigger_pattern_pkg::*;

	// free-running period counter
	logic [SELF_TRIGGER_LOG2-1:0] count;
	// counter sits at its last value and wraps on the next edge
	logic wrap;

	assign wrap = &count;

	always_ff @(posedge clock) begin
		if (reset1) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// first pulse one full period after reset
	always_ff @(posedge clock) begin
		if (reset1) begin
			self_pulse <= 1'b0;
		end else begin
			self_pulse <= wrap;
		end
	end

endmodule

`default_nettype wire

/* design/pattern_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_sequencer (
	input logic clock,
	input logic reset1,
	input trigger_pattern_pkg::trigger_event_t trigger_event,
	input logic self_pulse,
	input logic busy,
	output trigger_pattern_pkg::frame_t frame,
	output logic sync_flag
);

	import trigger_pattern_pkg::*;

	logic selected_pulse;
	logic accept;

	// frame request and sync state
	logic load_q;
	logic sync_q;
	// index of the next frame to send
	pattern_index_t next_index;

	// frame payload
	pattern_index_t frame_index;
	pattern_word_t frame_word;

	// self mode ignores the external trigger entirely
	assign selected_pulse = trigger_event.self_mode ? self_pulse : trigger_event.ext_pulse;

	// the load cycle itself counts as busy, busy only rises a cycle later
	assign accept = selected_pulse & ~busy & ~load_q;

	always_ff @(posedge clock) begin
		if (reset1) begin
			load_q <= 1'b0;
			sync_q <= 1'b0;
			next_index <= '0;
		end else begin
			load_q <= accept;
			if (accept) begin
				next_index <= next_index + 1'b1;
				// sync marks the start of a rotation
				if (next_index == 2'd0) begin
					sync_q <= 1'b1;
				end else if (next_index == 2'd1) begin
					sync_q <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			frame_index <= next_index;
			frame_word <= PATTERN_TABLE[next_index];
		end
	end

	assign frame = '{
		load: load_q,
		index: frame_index,
		word: frame_word
	};

	assign sync_flag = sync_q;

	// dropped triggers must not advance the rotation
	assert property (@(posedge clock) disable iff (reset1)
		$changed(next_index) |-> frame.load)
	else $error("pattern index changed without a load");

	// serializer never sees a load mid-frame
	assert property (@(posedge clock) disable iff (reset1)
		frame.load |-> !busy)
	else $error("load issued while serializer busy");

endmodule

`default_nettype wire

/* design/word_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module word_serializer (
	input logic clock,
	input logic reset1,
	input trigger_pattern_pkg::frame_t frame,
	output logic busy,
	output logic serial_out,
	output trigger_pattern_pkg::pattern_word_t pattern_leds
);

	import trigger_pattern_pkg::*;

	localparam logic [BIT_COUNT_WIDTH-1:0] LAST_BIT = BIT_COUNT_WIDTH'(WORD_WIDTH - 1);

	// outgoing word, MSB at the top
	pattern_word_t shift_q;
	// last loaded word shown on the LEDs
	pattern_word_t leds_q;
	logic [BIT_COUNT_WIDTH-1:0] bit_count;
	logic busy_q;

	always_ff @(posedge clock) begin
		if (reset1) begin
			busy_q <= 1'b0;
			bit_count <= '0;
			leds_q <= '0;
		end else if (frame.load) begin
			busy_q <= 1'b1;
			bit_count <= '0;
			leds_q <= frame.word;
		end else if (busy_q) begin
			bit_count <= bit_count + 1'b1;
			// last bit on the line this cycle
			if (bit_count == LAST_BIT) begin
				busy_q <= 1'b0;
			end
		end
	end

	// shift left with zero fill
	always_ff @(posedge clock) begin
		if (frame.load) begin
			shift_q <= frame.word;
		end else if (busy_q) begin
			shift_q <= {shift_q[WORD_WIDTH-2:0], 1'b0};
		end
	end

	// line idles low between frames
	assign serial_out = busy_q & shift_q[WORD_WIDTH-1];
	assign busy = busy_q;
	assign pattern_leds = leds_q;

	// one full word per load, then idle
	assert property (@(posedge clock) disable iff (reset1)
		frame.load |=> busy_q [*WORD_WIDTH] ##1 !busy_q)
	else $error("busy length differs from WORD_WIDTH");

endmodule

`default_nettype wire

/* design/trigger_pattern_top.sv */
`timescale 1ns/1ps
`default_nettype none

module trigger_pattern_top (
	input logic clock,
	input logic reset1,
	input logic trigger_level,
	input logic self_mode_switch,
	output logic serial_out,
	output logic frame_active,
	output logic sync_flag,
	output trigger_pattern_pkg::pattern_word_t pattern_leds
);

	import trigger_pattern_pkg::*;

	trigger_event_t trigger_event;
	logic self_pulse;
	frame_t frame;
	// serializer back-pressure
	logic busy;

	// input side
	trigger_input trigger_input_inst (
		.clock(clock),
		.reset1(reset1),
		.trigger_level(trigger_level),
		.self_mode_switch(self_mode_switch),
		.trigger_event(trigger_event)
	);

	self_trigger_timer self_trigger_timer_inst (
		.clock(clock),
		.reset1(reset1),
		.self_pulse(self_pulse)
	);

	// pattern rotation and sync
	pattern_sequencer pattern_sequencer_inst (
		.clock(clock),
		.reset1(reset1),
		.trigger_event(trigger_event),
		.self_pulse(self_pulse),
		.busy(busy),
		.frame(frame),
		.sync_flag(sync_flag)
	);

	// output side
	word_serializer word_serializer_inst (
		.clock(clock),
		.reset1(reset1),
		.frame(frame),
		.busy(busy),
		.serial_out(serial_out),
		.pattern_leds(pattern_leds)
	);

	// a frame is on the line exactly while the serializer is busy
	assign frame_active = busy;

endmodule

`default_nettype wire

/* verif/tb_trigger_tasks.svh */
`ifndef TB_TRIGGER_TASKS_SVH
`define TB_TRIGGER_TASKS_SVH

task automatic fail_run(input string reason);
	error_count++;
	$display("%s", reason);
	$display("=== FAIL ===");
	$fatal(1, "stopped at first error");
endtask

task automatic compare_word(input string name, input pattern_word_t actual,
		input pattern_word_t expected);
	if (actual !== expected) begin
		fail_run($sformatf("MISMATCH at %0t ns: %s is %b, expected %b",
			$time, name, actual, expected));
	end
endtask

task automatic compare_bit(input string name, input logic actual, input logic expected);
	if (actual !== expected) begin
		fail_run($sformatf("MISMATCH at %0t ns: %s is %b, expected %b",
			$time, name, actual, expected));
	end
endtask

task automatic compare_count(input string name, input int actual, input int expected);
	if (actual != expected) begin
		fail_run($sformatf("MISMATCH at %0t ns: %s is %0d, expected %0d",
			$time, name, actual, expected));
	end
endtask

task automatic next_drive_slot();
	@(posedge clock);
	#DRIVE_DELAY;
endtask

task automatic pulse_trigger(input int high_cycles);
	next_drive_slot();
	trigger_level = 1'b1;
	repeat (high_cycles) next_drive_slot();
	trigger_level = 1'b0;
endtask

// waits for frame_active, then takes one bit per cycle, MSB first
task automatic capture_frame(input int timeout_cycles, output pattern_word_t word,
		output int start_cycle);
	int waited;
	int bit_pos;
	waited = 0;
	@(negedge clock);
	while (frame_active !== 1'b1) begin
		if (waited >= timeout_cycles) begin
			fail_run($sformatf("ERROR: no frame started within %0d cycles, at %0t ns",
				timeout_cycles, $time));
		end
		waited++;
		@(negedge clock);
	end
	start_cycle = cycle_count;
	for (bit_pos = WORD_WIDTH - 1; bit_pos >= 0; bit_pos--) begin
		compare_bit("frame_active", frame_active, 1'b1);
		word[bit_pos] = serial_out;
		@(negedge clock);
	end
	// exactly WORD_WIDTH cycles, then the line idles low
	compare_bit("frame_active", frame_active, 1'b0);
	compare_bit("serial_out", serial_out, 1'b0);
endtask

task automatic expect_frame(input int timeout_cycles, output int start_cycle);
	pattern_word_t captured;
	pattern_word_t expected;
	expected = expected_table[model_index];
	if (model_index == 2'd0) begin
		model_sync = 1'b1;
	end else if (model_index == 2'd1) begin
		model_sync = 1'b0;
	end
	model_index = model_index + 2'd1;
	capture_frame(timeout_cycles, captured, start_cycle);
	compare_word("serial_out word", captured, expected);
	compare_word("pattern_leds", pattern_leds, expected);
	compare_bit("sync_flag", sync_flag, model_sync);
endtask

task automatic pulse_and_expect();
	int start_cycle;
	pulse_trigger(2);
	expect_frame(20, start_cycle);
	repeat (4) next_drive_slot();
endtask

task automatic check_idle(input int cycles);
	repeat (cycles) begin
		@(negedge clock);
		compare_bit("frame_active", frame_active, 1'b0);
		compare_bit("serial_out", serial_out, 1'b0);
	end
endtask

task automatic test_reset_state();
	@(negedge clock);
	compare_bit("serial_out", serial_out, 1'b0);
	compare_bit("frame_active", frame_active, 1'b0);
	compare_bit("sync_flag", sync_flag, 1'b0);
	compare_word("pattern_leds", pattern_leds, 8'h00);
	// longer than one timer period, ext mode ignores it
	check_idle(100);
endtask

task automatic test_rotation();
	repeat (8) pulse_and_expect();
endtask

task automatic test_sync_flag();
	int k;
	for (k = 0; k < 4; k++) begin
		pulse_and_expect();
		// set by index 0, cleared by index 1, then held
		compare_bit("sync_flag", sync_flag, (k == 0) ? 1'b1 : 1'b0);
	end
endtask

task automatic test_held_and_busy();
	int start_cycle;
	next_drive_slot();
	trigger_level = 1'b1;
	expect_frame(20, start_cycle);
	// level still high, no second frame
	check_idle(30);
	next_drive_slot();
	trigger_level = 1'b0;
	repeat (4) next_drive_slot();
	fork
		expect_frame(20, start_cycle);
		begin
			pulse_trigger(2);
			@(negedge clock);
			while (frame_active !== 1'b1) begin
				@(negedge clock);
			end
			// this rise lands while the frame is on the line
			pulse_trigger(2);
		end
	join
	check_idle(20);
	pulse_and_expect();
endtask

task automatic test_self_mode();
	int starts [0:3];
	int start_cycle;
	int gap;
	int k;
	// keep the mode change well clear of a timer pulse
	while (((cycle_count - release_cycle) % SELF_PERIOD) != 16) begin
		next_drive_slot();
	end
	self_mode_switch = 1'b1;
	repeat (3) next_drive_slot();
	fork
		for (k = 0; k < 4; k++) begin
			expect_frame(SELF_PERIOD + 16, start_cycle);
			starts[k] = start_cycle;
		end
		repeat (6) begin
			gap = int'((lcg_next() >> 16) % 32'd16) + 4;
			repeat (gap) next_drive_slot();
			pulse_trigger(2);
		end
	join
	for (k = 1; k < 4; k++) begin
		compare_count("self frame period", starts[k] - starts[k - 1], SELF_PERIOD);
	end
endtask

task automatic test_external_return();
	next_drive_slot();
	self_mode_switch = 1'b0;
	// two timer periods with no frame
	check_idle(2 * SELF_PERIOD + 20);
	pulse_and_expect();
endtask

`endif

/* verif/tb_trigger_pattern.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_trigger_pattern;

	import trigger_pattern_pkg::*;

	localparam int CLOCK_PERIOD = 4;
	localparam int DRIVE_DELAY = 1;
	localparam int SELF_PERIOD = 64;
	// rough length of all tests in clock cycles
	localparam int TEST_CYCLES = 1000;
	localparam int MARGIN_CYCLES = 200;

	logic clock;
	logic reset1;
	logic trigger_level;
	logic self_mode_switch;
	logic serial_out;
	logic frame_active;
	logic sync_flag;
	pattern_word_t pattern_leds;

	int cycle_count;
	// cycle count at reset release, the timer phase is taken from it
	int release_cycle;
	int error_count;
	logic [31:0] lcg_state;

	// reference model of the rotation
	pattern_index_t model_index;
	logic model_sync;
	pattern_word_t expected_table [0:3];

	trigger_pattern_top trigger_pattern_top_inst (
		.clock(clock),
		.reset1(reset1),
		.trigger_level(trigger_level),
		.self_mode_switch(self_mode_switch),
		.serial_out(serial_out),
		.frame_active(frame_active),
		.sync_flag(sync_flag),
		.pattern_leds(pattern_leds)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	`include "tb_trigger_tasks.svh"

	initial begin
		clock = 1'b0;
		forever begin
			#(CLOCK_PERIOD / 2) clock = ~clock;
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	// watchdog
	initial begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLOCK_PERIOD);
		$display("ERROR: watchdog expired at %0t ns, the tests did not finish", $time);
		$display("=== FAIL ===");
		$fatal(1, "watchdog timeout");
	end

	initial begin
		reset1 = 1'b1;
		trigger_level = 1'b0;
		self_mode_switch = 1'b0;
		cycle_count = 0;
		release_cycle = 0;
		error_count = 0;
		lcg_state = 32'hd5c1_e412;
		model_index = '0;
		model_sync = 1'b0;
		expected_table[0] = 8'b11110000;
		expected_table[1] = 8'b10000001;
		expected_table[2] = 8'b10001000;
		expected_table[3] = 8'b10101010;
		repeat (2) @(posedge clock);
		#DRIVE_DELAY;
		reset1 = 1'b0;
		release_cycle = cycle_count;
		test_reset_state();
		test_rotation();
		test_sync_flag();
		test_held_and_busy();
		test_self_mode();
		test_external_return();
		if (error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verif
design/trigger_pattern_pkg.sv
design/trigger_input.sv
design/self_trigger_timer.sv
design/pattern_sequencer.sv
design/word_serializer.sv
design/trigger_pattern_top.sv
verif/tb_trigger_pattern.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and search the log for the result
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_trigger_pattern -f compile.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "=== PASS ===" sim.log \
	&& echo "result: passed" \
	|| { echo "result: failed"; exit 1; }
